//--- ddr_ctrl.f
+incdir+hw
hw/sdram_cmd_pkg.sv
hw/ddr_bus_pkg.sv
hw/ddr_init_seq.sv
hw/ddr_refresh_timer.sv
hw/ddr_cmd_sched.sv
hw/ddr_ctrl_top.sv
test/sdram_model.sv
test/ddr_ctrl_tb.sv

//--- hw/ddr_bus_pkg.sv
// Bus request struct and SDRAM address split
`default_nettype none

`include "ddr_consts.svh"

package ddr_bus_pkg;

	typedef struct packed {
		logic [`DDR_BUS_ADR_W-1:0] adr;
		logic [`DDR_DQ_W-1:0] wdata;
		logic we;
		logic [`DDR_DQ_W/8-1:0] sel;
	} bus_req_t;

	// Bank in the top bits, column word index at the bottom
	typedef struct packed {
		logic [`DDR_BA_W-1:0] bank;
		logic [`DDR_ROW_W-1:0] row;
		logic [`DDR_COL_W-1:0] col;
	} ddr_addr_t;

endpackage

`default_nettype wire

//--- hw/ddr_cmd_sched.sv
// Access and refresh command FSM with write and read data paths
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module ddr_cmd_sched import sdram_cmd_pkg::*, ddr_bus_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic init_done_i,
	input wire logic ref_req_i,
	input wire bus_req_t bus_req_i,
	input wire logic bus_stb_i,
	input wire logic [`DDR_DQ_W-1:0] sdram_dq_i,
	output logic ref_ack_o,
	output sdram_cmd_t sched_cmd_o,
	output logic [`DDR_DQ_W-1:0] sdram_dq_o,
	output logic sdram_dq_oe_o,
	output logic [`DDR_DQ_W/8-1:0] sdram_dm_o,
	output logic bus_ack_o,
	output logic [`DDR_DQ_W-1:0] bus_rdata_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REFRESH,
		ST_ACTIVATE,
		ST_ACCESS,
		ST_READ_WAIT,
		ST_PRECHARGE
	} sched_state_t;

	sched_state_t state;
	logic first;
	logic [3:0] cnt;
	logic accept;
	logic start_ref;
	bus_req_t req;
	ddr_addr_t req_addr;
	logic [`DDR_A_W-1:0] col_a;

	assign start_ref = (state == ST_IDLE) && init_done_i && ref_req_i;
	assign accept = (state == ST_IDLE) && init_done_i && !ref_req_i && bus_stb_i;

	assign req_addr = ddr_addr_t'(req.adr);
	// BL2 column with A10 low, so no auto-precharge
	assign col_a = {{(`DDR_A_W - `DDR_COL_W - 1){1'b0}}, req_addr.col, 1'b0};

	// ---------------------------------------------------------------------
	// State machine
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			first <= 1'b0;
			cnt <= '0;
			sdram_dq_oe_o <= 1'b0;
			bus_ack_o <= 1'b0;
		end else begin
			first <= 1'b0;
			sdram_dq_oe_o <= 1'b0;
			bus_ack_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_ref) begin
						state <= ST_REFRESH;
						first <= 1'b1;
						cnt <= 4'(`DDR_TRFC - 1);
					end else if (accept) begin
						state <= ST_ACTIVATE;
						first <= 1'b1;
						cnt <= 4'(`DDR_TRCD - 1);
					end
				end
				ST_ACCESS: begin
					if (req.we) begin
						state <= ST_PRECHARGE;
						first <= 1'b1;
						cnt <= 4'(`DDR_TRP - 1);
						sdram_dq_oe_o <= 1'b1;
					end else begin
						state <= ST_READ_WAIT;
						cnt <= 4'(`DDR_CL - 1);
					end
				end
				default: begin
					// Timed states
					if (state == ST_PRECHARGE && first) begin
						bus_ack_o <= 1'b1;
					end
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (state == ST_ACTIVATE) begin
						state <= ST_ACCESS;
						first <= 1'b1;
					end else if (state == ST_READ_WAIT) begin
						state <= ST_PRECHARGE;
						first <= 1'b1;
						cnt <= 4'(`DDR_TRP - 1);
					end else begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Request and data registers
	always_ff @(posedge clk) begin
		if (accept) begin
			req <= bus_req_i;
		end
		if (state == ST_ACCESS) begin
			sdram_dq_o <= req.wdata;
			sdram_dm_o <= ~req.sel;
		end
		// Read data arrives CL edges after the edge that takes the read
		if (state == ST_PRECHARGE && first && !req.we) begin
			bus_rdata_o <= sdram_dq_i;
		end
	end

	// ---------------------------------------------------------------------
	// Command decode, registered again at the top level
	// ---------------------------------------------------------------------
	always_comb begin
		sched_cmd_o = make_cmd(1'b1, CMD_NOP, '0, '0);
		if (first) begin
			case (state)
				ST_REFRESH: sched_cmd_o = make_cmd(1'b1, CMD_REF, '0, '0);
				ST_ACTIVATE: sched_cmd_o = make_cmd(1'b1, CMD_ACT, req_addr.bank, req_addr.row);
				ST_ACCESS: sched_cmd_o = make_cmd(1'b1, req.we ? CMD_WRITE : CMD_READ,
					req_addr.bank, col_a);
				ST_PRECHARGE: sched_cmd_o = make_cmd(1'b1, CMD_PRE, req_addr.bank, '0);
				default: sched_cmd_o = make_cmd(1'b1, CMD_NOP, '0, '0);
			endcase
		end
	end

	assign ref_ack_o = first && (state == ST_REFRESH);

endmodule

`default_nettype wire

//--- hw/ddr_consts.svh
// Widths, timing counts and mode register values for the DDR controller
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

// ---------------------------------------------------------------------
// Pin and bus widths
// ---------------------------------------------------------------------
`define DDR_BA_W 2
`define DDR_A_W 13
`define DDR_DQ_W 32
`define DDR_BUS_ADR_W 22
`define DDR_COL_W 7
`define DDR_ROW_W 13

// ---------------------------------------------------------------------
// Timing in clock cycles
// ---------------------------------------------------------------------
// Short power-up wait for simulation
`define DDR_INIT_WAIT 200
`define DDR_STEP_WAIT 8
`define DDR_TRCD 2
`define DDR_TRP 2
`define DDR_TRFC 8
`define DDR_CL 2
`define DDR_REFI 120

// Mode words: DLL on, normal drive / CL 2, BL 2, sequential
`define DDR_EMRS_VAL 13'h0000
`define DDR_MRS_DLL_VAL 13'h0121
`define DDR_MRS_VAL 13'h0021

`endif

//--- hw/ddr_ctrl_top.sv
// DDR controller top with init sequencer, refresh timer, scheduler and pin register
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module ddr_ctrl_top import sdram_cmd_pkg::*, ddr_bus_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire bus_req_t bus_req_i,
	input wire logic bus_stb_i,
	input wire logic [`DDR_DQ_W-1:0] sdram_dq_i,
	output logic bus_ack_o,
	output logic [`DDR_DQ_W-1:0] bus_rdata_o,
	output sdram_cmd_t sdram_cmd_o,
	output logic [`DDR_DQ_W-1:0] sdram_dq_o,
	output logic sdram_dq_oe_o,
	output logic [`DDR_DQ_W/8-1:0] sdram_dm_o
);

	sdram_cmd_t init_cmd;
	sdram_cmd_t sched_cmd;
	logic init_done;
	logic ref_req;
	logic ref_ack;

	ddr_init_seq u_init_seq (
		.clk(clk),
		.reset(reset),
		.init_cmd_o(init_cmd),
		.init_done_o(init_done)
	);

	ddr_refresh_timer u_refresh_timer (
		.clk(clk),
		.reset(reset),
		.init_done_i(init_done),
		.ref_ack_i(ref_ack),
		.ref_req_o(ref_req)
	);

	ddr_cmd_sched u_cmd_sched (
		.clk(clk),
		.reset(reset),
		.init_done_i(init_done),
		.ref_req_i(ref_req),
		.bus_req_i(bus_req_i),
		.bus_stb_i(bus_stb_i),
		.sdram_dq_i(sdram_dq_i),
		.ref_ack_o(ref_ack),
		.sched_cmd_o(sched_cmd),
		.sdram_dq_o(sdram_dq_o),
		.sdram_dq_oe_o(sdram_dq_oe_o),
		.sdram_dm_o(sdram_dm_o),
		.bus_ack_o(bus_ack_o),
		.bus_rdata_o(bus_rdata_o)
	);

	// ---------------------------------------------------------------------
	// Command pin register
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sdram_cmd_o <= SDRAM_CMD_RESET;
		end else begin
			sdram_cmd_o <= init_done ? sched_cmd : init_cmd;
		end
	end

endmodule

`default_nettype wire

//--- hw/ddr_init_seq.sv
// Power-up wait, CKE enable and mode register programming sequence
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module ddr_init_seq import sdram_cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	output sdram_cmd_t init_cmd_o,
	output logic init_done_o
);

	localparam int CNT_W = 16;

	// Precharge all banks
	localparam logic [`DDR_A_W-1:0] A_PALL = `DDR_A_W'(1 << 10);

	typedef enum logic [3:0] {
		ST_WAIT,
		ST_CKE,
		ST_PALL1,
		ST_EMRS,
		ST_MRS1,
		ST_PALL2,
		ST_REF1,
		ST_REF2,
		ST_MRS2,
		ST_DONE
	} init_state_t;

	init_state_t state;
	logic [CNT_W-1:0] cnt;

	// ---------------------------------------------------------------------
	// Step counter and command register
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_WAIT;
			// Two less so the pin register lands on the full count
			cnt <= CNT_W'(`DDR_INIT_WAIT - 2);
			init_cmd_o <= SDRAM_CMD_RESET;
			init_done_o <= 1'b0;
		end else begin
			// Deselect between commands
			init_cmd_o <= make_cmd(state != ST_WAIT, CMD_DSEL, '0, '0);
			if (state != ST_DONE) begin
				if (cnt != '0) begin
					cnt <= cnt - 1'b1;
				end else begin
					cnt <= CNT_W'(`DDR_STEP_WAIT - 1);
					case (state)
						ST_WAIT: begin
							init_cmd_o <= make_cmd(1'b1, CMD_DSEL, '0, '0);
							state <= ST_CKE;
						end
						ST_CKE: begin
							init_cmd_o <= make_cmd(1'b1, CMD_PRE, '0, A_PALL);
							state <= ST_PALL1;
						end
						ST_PALL1: begin
							init_cmd_o <= make_cmd(1'b1, CMD_MRS, 2'b01, `DDR_EMRS_VAL);
							state <= ST_EMRS;
						end
						ST_EMRS: begin
							init_cmd_o <= make_cmd(1'b1, CMD_MRS, 2'b00, `DDR_MRS_DLL_VAL);
							state <= ST_MRS1;
						end
						ST_MRS1: begin
							init_cmd_o <= make_cmd(1'b1, CMD_PRE, '0, A_PALL);
							state <= ST_PALL2;
						end
						ST_PALL2: begin
							init_cmd_o <= make_cmd(1'b1, CMD_REF, '0, '0);
							state <= ST_REF1;
						end
						ST_REF1: begin
							init_cmd_o <= make_cmd(1'b1, CMD_REF, '0, '0);
							state <= ST_REF2;
						end
						ST_REF2: begin
							init_cmd_o <= make_cmd(1'b1, CMD_MRS, 2'b00, `DDR_MRS_VAL);
							state <= ST_MRS2;
						end
						ST_MRS2: begin
							init_done_o <= 1'b1;
							state <= ST_DONE;
						end
						default: begin
							state <= ST_DONE;
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/ddr_refresh_timer.sv
// Periodic auto-refresh request counter
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module ddr_refresh_timer (
	input wire logic clk,
	input wire logic reset,
	input wire logic init_done_i,
	input wire logic ref_ack_i,
	output logic ref_req_o
);

	localparam int CNT_W = 16;

	logic [CNT_W-1:0] cnt;
	logic expire;

	// Held at full count until initialization ends
	assign expire = init_done_i && (cnt == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= CNT_W'(`DDR_REFI - 1);
			ref_req_o <= 1'b0;
		end else begin
			if (expire) begin
				cnt <= CNT_W'(`DDR_REFI - 1);
			end else if (init_done_i) begin
				cnt <= cnt - 1'b1;
			end
			// A pending request absorbs a second expiry
			ref_req_o <= (ref_req_o && !ref_ack_i) || expire;
		end
	end

endmodule

`default_nettype wire

//--- hw/sdram_cmd_pkg.sv
// SDRAM command-pin struct, command encodings and command builder
`default_nettype none

`include "ddr_consts.svh"

package sdram_cmd_pkg;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [`DDR_BA_W-1:0] ba;
		logic [`DDR_A_W-1:0] a;
	} sdram_cmd_t;

	// {cs_n, ras_n, cas_n, we_n}
	typedef logic [3:0] cmd_code_t;

	localparam cmd_code_t CMD_DSEL  = 4'b1111;
	localparam cmd_code_t CMD_NOP   = 4'b0111;
	localparam cmd_code_t CMD_ACT   = 4'b0011;
	localparam cmd_code_t CMD_READ  = 4'b0101;
	localparam cmd_code_t CMD_WRITE = 4'b0100;
	localparam cmd_code_t CMD_PRE   = 4'b0010;
	localparam cmd_code_t CMD_REF   = 4'b0001;
	localparam cmd_code_t CMD_MRS   = 4'b0000;

	// Clock disabled and deselected
	localparam sdram_cmd_t SDRAM_CMD_RESET = '{cke: 1'b0, cs_n: 1'b1, ras_n: 1'b1,
		cas_n: 1'b1, we_n: 1'b1, ba: '0, a: '0};

	function automatic sdram_cmd_t make_cmd(input logic cke, input cmd_code_t code,
			input logic [`DDR_BA_W-1:0] ba, input logic [`DDR_A_W-1:0] a);
		return sdram_cmd_t'{cke: cke, cs_n: code[3], ras_n: code[2], cas_n: code[1],
			we_n: code[0], ba: ba, a: a};
	endfunction

endpackage

`default_nettype wire

//--- test/ddr_ctrl_tb.sv
// Testbench for the DDR controller with random bus traffic and a reference memory
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module ddr_ctrl_tb import sdram_cmd_pkg::*, ddr_bus_pkg::*; ();

	localparam int ACK_TIMEOUT = 200;
	localparam int NUM_OPS = 160;
	localparam logic [2:0] CODE_NOP = 3'b111;
	localparam logic [2:0] CODE_PRE = 3'b010;
	localparam logic [2:0] CODE_REF = 3'b001;
	localparam logic [2:0] CODE_MRS = 3'b000;

	typedef struct packed {
		logic [2:0] code;
		logic [`DDR_BA_W-1:0] ba;
		logic [`DDR_A_W-1:0] a;
		logic [`DDR_A_W-1:0] mask;
	} init_step_t;

	logic clk;
	logic reset;
	bus_req_t bus_req;
	logic bus_stb;
	logic bus_ack;
	logic [`DDR_DQ_W-1:0] bus_rdata;
	sdram_cmd_t sdram_cmd;
	logic [`DDR_DQ_W-1:0] dq_to_ctrl;
	logic [`DDR_DQ_W-1:0] dq_from_ctrl;
	logic dq_oe;
	logic [`DDR_DQ_W/8-1:0] dm;
	int model_errors;

	int cyc;
	int errors;
	int mark;
	int tests_run;
	int tests_failed;
	int requests;
	int acks;
	logic timed_out;
	logic [31:0] rng;
	logic [`DDR_DQ_W-1:0] ref_mem [logic [`DDR_BUS_ADR_W-1:0]];

	ddr_ctrl_top DUT (
		.clk(clk),
		.reset(reset),
		.bus_req_i(bus_req),
		.bus_stb_i(bus_stb),
		.sdram_dq_i(dq_to_ctrl),
		.bus_ack_o(bus_ack),
		.bus_rdata_o(bus_rdata),
		.sdram_cmd_o(sdram_cmd),
		.sdram_dq_o(dq_from_ctrl),
		.sdram_dq_oe_o(dq_oe),
		.sdram_dm_o(dm)
	);

	sdram_model sdram (
		.clk(clk),
		.reset(reset),
		.cmd_i(sdram_cmd),
		.dq_i(dq_from_ctrl),
		.dq_oe_i(dq_oe),
		.dm_i(dm),
		.req_adr_i(bus_req.adr),
		.dq_o(dq_to_ctrl),
		.errors_o(model_errors)
	);

	always #10 clk = ~clk;

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	always @(negedge clk) begin
		if (bus_ack === 1'b1) begin
			acks++;
		end
	end

	// ---------------------------------------------------------------------
	// Helpers
	// ---------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Expected power-up command list
	// PALL is compared on A10 only
	function automatic init_step_t init_step(input int i);
		case (i)
			0, 3: return '{CODE_PRE, 2'b00, 13'h0400, 13'h0400};
			1: return '{CODE_MRS, 2'b01, `DDR_EMRS_VAL, '1};
			2: return '{CODE_MRS, 2'b00, `DDR_MRS_DLL_VAL, '1};
			4, 5: return '{CODE_REF, 2'b00, 13'h0000, 13'h0000};
			default: return '{CODE_MRS, 2'b00, `DDR_MRS_VAL, '1};
		endcase
	endfunction

	task automatic log_mismatch(input string msg);
		$display("FAILED %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic close_test(input string name, input logic from_model);
		int n;
		if (from_model) begin
			n = model_errors;
		end else begin
			n = errors - mark;
			mark = errors;
		end
		tests_run++;
		if (n == 0) begin
			$display("test %-22s ok", name);
		end else begin
			$display("test %-22s %0d errors", name, n);
			tests_failed++;
		end
	endtask

	task automatic check_startup_pins();
		assert (sdram_cmd.cs_n === 1'b1) else log_mismatch("cs_n low before first command");
		assert (cyc >= `DDR_INIT_WAIT || sdram_cmd.cke === 1'b0) else
			log_mismatch("CKE high during power-up wait");
		assert (bus_ack === 1'b0) else log_mismatch("acknowledge during startup");
	endtask

	task automatic wait_init_cmd(input int limit, input logic startup, output int seen,
			output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < limit) begin
			@(negedge clk);
			n++;
			if (sdram_cmd.cs_n === 1'b0 &&
					{sdram_cmd.ras_n, sdram_cmd.cas_n, sdram_cmd.we_n} != CODE_NOP) begin
				ok = 1'b1;
			end else if (startup) begin
				check_startup_pins();
			end
		end
		seen = cyc;
	endtask

	task automatic run_access(input logic we, input logic [`DDR_BUS_ADR_W-1:0] adr,
			input logic [`DDR_DQ_W-1:0] data, input logic [`DDR_DQ_W/8-1:0] sel);
		int n;
		logic got_ack;
		logic [`DDR_DQ_W-1:0] expected;
		expected = ref_mem.exists(adr) ? ref_mem[adr] : '0;
		bus_req.adr = adr;
		bus_req.wdata = data;
		bus_req.we = we;
		bus_req.sel = sel;
		bus_stb = 1'b1;
		requests++;
		got_ack = 1'b0;
		n = 0;
		while (!got_ack && n < ACK_TIMEOUT) begin
			@(negedge clk);
			n++;
			got_ack = (bus_ack === 1'b1);
		end
		bus_stb = 1'b0;
		if (!got_ack) begin
			$display("Timeout: acknowledge never came for address %h", adr);
			errors++;
			timed_out = 1'b1;
		end else begin
			if (we) begin
				for (int b = 0; b < `DDR_DQ_W / 8; b++) begin
					if (sel[b]) begin
						expected[8*b +: 8] = data[8*b +: 8];
					end
				end
				ref_mem[adr] = expected;
			end else begin
				assert (bus_rdata === expected) else log_mismatch($sformatf(
					"read %h returned %h, expected %h", adr, bus_rdata, expected));
			end
			@(negedge clk);
			assert (bus_ack === 1'b0) else log_mismatch("acknowledge longer than one cycle");
		end
	endtask

	// ---------------------------------------------------------------------
	// Test sequence
	// ---------------------------------------------------------------------
	initial begin
		init_step_t st;
		int seen;
		int prev;
		int gap;
		logic ok;
		logic [31:0] r;
		logic [31:0] g;
		logic [`DDR_BUS_ADR_W-1:0] adr;
		logic [`DDR_BUS_ADR_W-1:0] last_adr;
		clk = 1'b0;
		reset = 1'b1;
		bus_stb = 1'b0;
		bus_req = '0;
		rng = 32'h3a6d_f821;
		errors = 0;
		mark = 0;
		tests_run = 0;
		tests_failed = 0;
		requests = 0;
		acks = 0;
		timed_out = 1'b0;
		last_adr = '0;
		prev = 0;
		repeat (5) begin
			@(negedge clk);
			check_startup_pins();
		end
		reset = 1'b0;

		wait_init_cmd(`DDR_INIT_WAIT + 4 * `DDR_STEP_WAIT, 1'b1, seen, ok);
		close_test("reset state", 1'b0);
		for (int i = 0; i < 7 && !timed_out; i++) begin
			if (i > 0) begin
				wait_init_cmd(4 * `DDR_STEP_WAIT, 1'b0, seen, ok);
			end
			if (!ok) begin
				$display("Timeout: initialization command %0d never appeared", i);
				errors++;
				timed_out = 1'b1;
			end else begin
				st = init_step(i);
				assert ({sdram_cmd.ras_n, sdram_cmd.cas_n, sdram_cmd.we_n} == st.code &&
						(sdram_cmd.a & st.mask) == (st.a & st.mask) &&
						(st.code != CODE_MRS || sdram_cmd.ba == st.ba)) else
					log_mismatch($sformatf("init command %0d has wrong encoding", i));
				assert (seen == ((i == 0) ? `DDR_INIT_WAIT + `DDR_STEP_WAIT :
						prev + `DDR_STEP_WAIT)) else
					log_mismatch($sformatf("init command %0d at cycle %0d", i, seen));
				prev = seen;
			end
		end
		close_test("init order", 1'b0);

		for (int i = 0; i < NUM_OPS && !timed_out; i++) begin
			r = next_random();
			adr = {r[1:0], 10'd0, r[4:2], 4'd0, r[7:5]};
			case (r[13:12])
				2'd0, 2'd1: begin
					run_access(1'b1, adr, next_random(), r[11:8]);
					last_adr = adr;
				end
				2'd2: run_access(1'b0, adr, '0, 4'hf);
				default: run_access(1'b0, last_adr, '0, 4'hf);
			endcase
			// Mostly short gaps, sometimes several refresh intervals
			g = next_random();
			gap = (g[2:0] == 3'd0) ? int'(g[31:8] % (3 * `DDR_REFI)) : int'(g[9:8]);
			repeat (gap) @(negedge clk);
		end
		repeat (4) @(negedge clk);
		close_test("random traffic", 1'b0);
		assert (acks == requests) else
			log_mismatch($sformatf("%0d acknowledges for %0d requests", acks, requests));
		close_test("acknowledge count", 1'b0);
		close_test("protocol and refresh", 1'b1);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors + model_errors);
		if (tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sdram_model.sv
// Behavioral SDRAM with command protocol checks, word storage and read pipeline
`timescale 1ns/1ps
`default_nettype none

`include "ddr_consts.svh"

module sdram_model import sdram_cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire sdram_cmd_t cmd_i,
	input wire logic [`DDR_DQ_W-1:0] dq_i,
	input wire logic dq_oe_i,
	input wire logic [`DDR_DQ_W/8-1:0] dm_i,
	input wire logic [`DDR_BUS_ADR_W-1:0] req_adr_i,
	output logic [`DDR_DQ_W-1:0] dq_o,
	output int errors_o
);

	// {ras_n, cas_n, we_n} with cs_n low
	localparam logic [2:0] CODE_NOP = 3'b111;
	localparam logic [2:0] CODE_ACT = 3'b011;
	localparam logic [2:0] CODE_READ = 3'b101;
	localparam logic [2:0] CODE_WRITE = 3'b100;
	localparam logic [2:0] CODE_PRE = 3'b010;
	localparam logic [2:0] CODE_REF = 3'b001;
	localparam logic [2:0] CODE_MRS = 3'b000;

	// Refresh interval plus one full read access
	localparam int REF_GAP_MAX = `DDR_REFI + `DDR_TRCD + `DDR_CL + `DDR_TRP + 4;
	// Final mode set and init_done follow the last init refresh one step apart each
	localparam int REF_GAP_FIRST = REF_GAP_MAX + 2 * `DDR_STEP_WAIT;

	logic [`DDR_DQ_W-1:0] mem [logic [`DDR_BUS_ADR_W-1:0]];
	logic [`DDR_DQ_W-1:0] rd_pipe [`DDR_CL];
	logic [3:0] open_banks;
	logic [`DDR_ROW_W-1:0] open_row [4];
	int act_cyc [4];
	int cyc;
	int pre_cyc;
	int ref_cyc;
	int ref_cnt;
	logic late;
	logic [2:0] code;
	logic [`DDR_BUS_ADR_W-1:0] key;
	logic [`DDR_DQ_W-1:0] word;

	assign code = {cmd_i.ras_n, cmd_i.cas_n, cmd_i.we_n};
	assign dq_o = rd_pipe[`DDR_CL-1];

	task automatic flag_error(input string msg);
		$display("FAILED %0d ns: sdram %s", $time, msg);
		errors_o++;
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cyc = 0;
			open_banks = '0;
			pre_cyc = -1000;
			ref_cyc = -1000;
			ref_cnt = 0;
			late = 1'b0;
			errors_o = 0;
			for (int i = 0; i < `DDR_CL; i++) begin
				rd_pipe[i] <= '0;
			end
		end else begin
			cyc++;
			for (int i = `DDR_CL - 1; i > 0; i--) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
			rd_pipe[0] <= '0;
			// Gaps count from the last init refresh on
			assert (late || ref_cnt < 2 ||
					cyc - ref_cyc <= ((ref_cnt == 2) ? REF_GAP_FIRST : REF_GAP_MAX)) else begin
				flag_error("refresh interval exceeded");
				late = 1'b1;
			end
			assert (!dq_oe_i || (cmd_i.cs_n == 1'b0 && code == CODE_WRITE)) else
				flag_error("data enable without write");
			if (cmd_i.cs_n == 1'b0 && code != CODE_NOP) begin
				assert (cyc - pre_cyc >= `DDR_TRP) else flag_error("command inside tRP");
				assert (cyc - ref_cyc >= `DDR_TRFC) else flag_error("command inside tRFC");
				key = {cmd_i.ba, open_row[cmd_i.ba], cmd_i.a[`DDR_COL_W:1]};
				case (code)
					CODE_ACT: begin
						assert (!open_banks[cmd_i.ba]) else flag_error("activate to open bank");
						open_banks[cmd_i.ba] = 1'b1;
						open_row[cmd_i.ba] = cmd_i.a;
						act_cyc[cmd_i.ba] = cyc;
					end
					CODE_READ, CODE_WRITE: begin
						assert (open_banks[cmd_i.ba]) else flag_error("access to closed bank");
						assert (cyc - act_cyc[cmd_i.ba] >= `DDR_TRCD) else
							flag_error("access inside tRCD");
						assert (key == req_adr_i && cmd_i.a[0] == 1'b0 && cmd_i.a[10] == 1'b0)
							else flag_error($sformatf("access to %h for request %h", key, req_adr_i));
						word = mem.exists(key) ? mem[key] : '0;
						if (code == CODE_READ) begin
							rd_pipe[0] <= word;
						end else begin
							assert (dq_oe_i) else flag_error("write without data enable");
							for (int b = 0; b < `DDR_DQ_W / 8; b++) begin
								if (!dm_i[b]) begin
									word[8*b +: 8] = dq_i[8*b +: 8];
								end
							end
							mem[key] = word;
						end
					end
					CODE_PRE: begin
						if (cmd_i.a[10]) begin
							open_banks = '0;
						end else begin
							open_banks[cmd_i.ba] = 1'b0;
						end
						pre_cyc = cyc;
					end
					CODE_REF: begin
						assert (open_banks == '0) else flag_error("refresh with open bank");
						ref_cnt++;
						ref_cyc = cyc;
					end
					CODE_MRS: begin
						assert (open_banks == '0) else flag_error("mode set with open bank");
					end
					default: begin
						flag_error("unknown command on the pins");
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire
